//--- alu/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
	input  logic               clock,
	input  logic               rst_n,
	operand_if.alu             ops,
	output logic               wr_en,
	output exec_pkg::reg_addr_t wr_addr,
	output exec_pkg::word_t     wr_data,
	output logic               wb_valid,
	output exec_pkg::reg_addr_t wb_addr,
	output exec_pkg::word_t     wb_data,
	output logic               carry
);
	import exec_pkg::*;

	logic                  carry_q;
	logic                  cin;
	logic [SHIFT_BITS-1:0] shamt;
	logic [WORD_W:0]       res;    // bit 16 is carry or borrow out
	logic                  carry_upd;

	assign cin   = ops.use_carry & carry_q;
	assign shamt = ops.b[SHIFT_BITS-1:0];

	always_comb begin
		case (ops.alu_op)
			ALU_ADD:    res = {1'b0, ops.a} + {1'b0, ops.b} + {{WORD_W{1'b0}}, cin};
			ALU_SUB:    res = {1'b0, ops.a} - {1'b0, ops.b} - {{WORD_W{1'b0}}, cin};
			ALU_AND:    res = {1'b0, ops.a & ops.b};
			ALU_OR:     res = {1'b0, ops.a | ops.b};
			ALU_XOR:    res = {1'b0, ops.a ^ ops.b};
			ALU_ASR:    res = {1'b0, word_t'($signed(ops.a) >>> shamt)};  // sign fill
			ALU_LSL:    res = {1'b0, ops.a << shamt};
			ALU_LSR:    res = {1'b0, ops.a >> shamt};
			ALU_PASS_A: res = {1'b0, ops.a};
			ALU_PASS_B: res = {1'b0, ops.b};
			default:    res = '0;
		endcase
	end

	// write port goes straight to the register file this cycle
	assign wr_en   = ops.exec_en && (ops.alu_op != ALU_NONE);
	assign wr_addr = ops.dest;
	assign wr_data = res[WORD_W-1:0];

	// only carry mode add/sub touch the flag
	assign carry_upd = wr_en && ops.use_carry &&
		(ops.alu_op == ALU_ADD || ops.alu_op == ALU_SUB);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			carry_q  <= 1'b0;
		end else begin
			wb_valid <= wr_en;
			if (carry_upd) begin
				carry_q <= res[WORD_W];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			wb_addr <= wr_addr;
			wb_data <= wr_data;
		end
	end

	assign carry = carry_q;

endmodule

`default_nettype wire

//--- branch/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  logic           clock,
	input  logic           rst_n,
	operand_if.br          ops,
	output logic           branch_taken,
	output exec_pkg::word_t pc_offset,
	output logic           halted
);
	import exec_pkg::*;

	logic cond_met;
	logic take;

	// compares register values, not register numbers
	always_comb begin
		case (ops.br_cond)
			BR_ALWAYS: cond_met = 1'b1;
			BR_EQ:     cond_met = (ops.a == ops.b);
			BR_NE:     cond_met = (ops.a != ops.b);
			BR_LT:     cond_met = ($signed(ops.a) < $signed(ops.b));
			BR_GT:     cond_met = ($signed(ops.a) > $signed(ops.b));
			BR_LTU:    cond_met = (ops.a < ops.b);
			BR_GTU:    cond_met = (ops.a > ops.b);
			default:   cond_met = 1'b0;
		endcase
	end

	assign take = ops.exec_en & cond_met;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			branch_taken <= 1'b0;
			halted       <= 1'b0;
		end else begin
			branch_taken <= take;      // single cycle pulse
			if (ops.halt_req) begin
				halted <= 1'b1;        // sticky until reset
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			pc_offset <= ops.offset;
		end
	end

endmodule

`default_nettype wire

//--- common/exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam int WORD_W      = 16;
	localparam int ADDR_W      = 6;
	localparam int IMM_W       = 16;
	localparam int NUM_REGS    = 64;
	localparam int SHIFT_BITS  = 4;   // low operand bits used as shift amount

	localparam int IMM_SMALL_W = 6;   // add/sub/shift immediates, zero extended
	localparam int IMM_LOGIC_W = 9;   // and/or/xor immediates, zero extended
	localparam int IMM_COND_W  = 10;  // conditional branch offset, sign extended

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] reg_addr_t;
	typedef logic [IMM_W-1:0]  imm_t;

	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,   // breakpoint when imm is zero
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_ASR  = 6'd6,
		OP_LSL  = 6'd7,
		OP_LSR  = 6'd8,
		OP_MOV  = 6'd9,
		OP_ADDI = 6'd10,
		OP_SUBI = 6'd11,
		OP_ASRI = 6'd12,
		OP_LSLI = 6'd13,
		OP_LSRI = 6'd14,
		OP_MOVI = 6'd15,
		OP_BR   = 6'd32,  // full 16 bit offset
		OP_BEQ  = 6'd34,
		OP_BNE  = 6'd35,
		OP_BLT  = 6'd36,
		OP_BGT  = 6'd37,
		OP_BLTU = 6'd38,
		OP_BGTU = 6'd39
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_ASR,
		ALU_LSL,
		ALU_LSR,
		ALU_PASS_A,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GT,
		BR_LTU,
		BR_GTU
	} br_cond_t;

endpackage

`default_nettype wire

//--- common/operand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface operand_if;
	import exec_pkg::*;

	alu_op_t   alu_op;
	br_cond_t  br_cond;
	word_t     a;
	word_t     b;          // register value or extended immediate
	word_t     offset;     // branch offset, already extended
	logic      use_carry;
	reg_addr_t dest;
	logic      exec_en;    // valid and not halted
	logic      halt_req;

	modport dec (output alu_op, br_cond, a, b, offset, use_carry, dest, exec_en, halt_req);

	modport alu (input alu_op, a, b, use_carry, dest, exec_en);

	modport br (input br_cond, a, b, offset, exec_en, halt_req);

endinterface

`default_nettype wire

//--- regfile/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic               clock,
	input  logic               rst_n,
	input  exec_pkg::reg_addr_t rd_addr_a,
	input  exec_pkg::reg_addr_t rd_addr_b,
	output exec_pkg::word_t     rd_data_a,
	output exec_pkg::word_t     rd_data_b,
	input  logic               wr_en,
	input  exec_pkg::reg_addr_t wr_addr,
	input  exec_pkg::word_t     wr_data
);
	import exec_pkg::*;

	word_t regs [NUM_REGS];

	// reads see the array directly, a write lands at the next edge
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds exec_tb with Verilator, runs it and looks for the pass line in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module exec_tb \
	-Mdir obj_dir -o exec_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/exec_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- verification/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// expected state of the outputs in the cycle after an instruction
typedef struct packed {
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      carry;
	logic      branch_taken;
	word_t     pc_offset;
	logic      halted;
} expect_t;

word_t       shadow_regs [NUM_REGS];
logic        shadow_carry;
logic        shadow_halted;
logic [31:0] rng_state;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] next_rand();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

function automatic void clear_shadow();
	for (int i = 0; i < NUM_REGS; i++) begin
		shadow_regs[i] = '0;
	end
	shadow_carry  = 1'b0;
	shadow_halted = 1'b0;
endfunction

// keep the low bits of the immediate
function automatic word_t zero_ext(input imm_t value, input int bits);
	return value & word_t'((1 << bits) - 1);
endfunction

function automatic word_t sign_ext(input imm_t value, input int bits);
	word_t shifted;
	shifted = value << (WORD_W - bits);  // field sign moves to bit 15
	return word_t'($signed(shifted) >>> (WORD_W - bits));
endfunction

function automatic word_t shift_right_arith(input word_t a, input logic [SHIFT_BITS-1:0] amt);
	word_t r;
	r = a >> amt;
	if (a[WORD_W-1]) begin
		r = r | ~(16'hffff >> amt);  // refill vacated bits with the sign
	end
	return r;
endfunction

function automatic logic branch_holds(input opcode_t op, input word_t a, input word_t b);
	int ua;
	int ub;
	int bias_a;
	int bias_b;
	ua     = int'(a);
	ub     = int'(b);
	// signed order is the unsigned order with the sign bit flipped
	bias_a = int'(a ^ 16'h8000);
	bias_b = int'(b ^ 16'h8000);
	case (op)
		OP_BEQ:  return ua == ub;
		OP_BNE:  return ua != ub;
		OP_BLT:  return bias_a < bias_b;
		OP_BGT:  return bias_a > bias_b;
		OP_BLTU: return ua < ub;
		OP_BGTU: return ua > ub;
		default: return 1'b0;
	endcase
endfunction

// applies one instruction to the shadow state, returns the expected outputs
function automatic expect_t model_step(input logic valid, input opcode_t op,
		input reg_addr_t d, input reg_addr_t sa, input reg_addr_t sb,
		input imm_t value, input logic uc, input logic ui);
	expect_t e;
	word_t   a;
	word_t   b;
	word_t   r;
	int      wide;
	logic    wr;
	e  = '0;
	a  = shadow_regs[sa];
	b  = shadow_regs[sb];
	r  = '0;
	wr = 1'b1;
	if (valid && !shadow_halted) begin
		case (op)
			OP_ADD: begin
				wide = int'(a) + int'(b) + int'(uc & shadow_carry);
				r    = word_t'(wide);
				if (uc) shadow_carry = (wide > 32'hffff);
			end
			OP_SUB: begin
				wide = int'(a) - int'(b) - int'(uc & shadow_carry);
				r    = word_t'(wide);
				if (uc) shadow_carry = (wide < 0);  // borrow
			end
			OP_AND:  r = a & (ui ? zero_ext(value, IMM_LOGIC_W) : b);
			OP_OR:   r = a | (ui ? zero_ext(value, IMM_LOGIC_W) : b);
			OP_XOR:  r = a ^ (ui ? zero_ext(value, IMM_LOGIC_W) : b);
			OP_ASR:  r = shift_right_arith(a, b[SHIFT_BITS-1:0]);
			OP_LSL:  r = a << b[SHIFT_BITS-1:0];
			OP_LSR:  r = a >> b[SHIFT_BITS-1:0];
			OP_MOV:  r = a;
			OP_ADDI: r = a + zero_ext(value, IMM_SMALL_W);
			OP_SUBI: r = a - zero_ext(value, IMM_SMALL_W);
			OP_ASRI: r = shift_right_arith(a, value[SHIFT_BITS-1:0]);
			OP_LSLI: r = a << value[SHIFT_BITS-1:0];
			OP_LSRI: r = a >> value[SHIFT_BITS-1:0];
			OP_MOVI: r = value;
			OP_BR: begin
				wr             = 1'b0;
				e.branch_taken = 1'b1;
				e.pc_offset    = value;
			end
			OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLTU, OP_BGTU: begin
				wr             = 1'b0;
				e.branch_taken = branch_holds(op, a, b);
				e.pc_offset    = sign_ext(value, IMM_COND_W);
			end
			default: begin
				wr = 1'b0;
				if (op == OP_NOP && value == '0) shadow_halted = 1'b1;  // breakpoint
			end
		endcase
		if (wr) begin
			shadow_regs[d] = r;
			e.wb_valid     = 1'b1;
			e.wb_addr      = d;
			e.wb_data      = r;
		end
	end
	e.carry  = shadow_carry;
	e.halted = shadow_halted;
	return e;
endfunction

`endif

//--- verification/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
	import exec_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int N_REG        = 200;
	localparam int N_IMM        = 150;
	localparam int N_CARRY      = 80;
	localparam int N_BRANCH     = 150;
	localparam int N_NOP        = 20;
	localparam int N_POST       = 50;
	// two register sweeps, the random phases and a few idle slots
	localparam int NUM_INSTR    = 2 * NUM_REGS + N_REG + N_IMM + N_CARRY + N_BRANCH
		+ N_NOP + N_POST + 8;
	localparam int CYCLE_LIMIT  = 3 * NUM_INSTR + 600;

	logic      clock;
	logic      rst_n;
	logic      instr_valid;
	opcode_t   opcode;
	reg_addr_t dest;
	reg_addr_t src_a;
	reg_addr_t src_b;
	imm_t      imm;
	logic      use_carry;
	logic      use_imm;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      carry;
	logic      branch_taken;
	word_t     pc_offset;
	logic      halted;

	`include "exec_ref.svh"

	expect_t   exp_q [$];
	string     name_q [$];
	expect_t   cur;
	string     cur_name;
	logic      have_cur = 1'b0;
	reg_addr_t last_dest = '0;
	int        check_count = 0;
	int        mismatch_count = 0;
	int        other_errors = 0;
	int        cycle_count = 0;

	opcode_t reg_ops [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ASR, OP_LSL, OP_LSR,
		OP_MOV};
	opcode_t imm_ops [9] = '{OP_ADDI, OP_SUBI, OP_ASRI, OP_LSLI, OP_LSRI, OP_MOVI, OP_AND,
		OP_OR, OP_XOR};
	opcode_t carry_ops [8] = '{OP_ADD, OP_SUB, OP_ADD, OP_SUB, OP_ADDI, OP_SUBI, OP_AND, OP_MOV};
	opcode_t br_ops [7] = '{OP_BR, OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLTU, OP_BGTU};

	exec_top u_exec_top (
		.clock        (clock),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.opcode       (opcode),
		.dest         (dest),
		.src_a        (src_a),
		.src_b        (src_b),
		.imm          (imm),
		.use_carry    (use_carry),
		.use_imm      (use_imm),
		.wb_valid     (wb_valid),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.carry        (carry),
		.branch_taken (branch_taken),
		.pc_offset    (pc_offset),
		.halted       (halted)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic check_word(input string what, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s: expected %h, actual %h", what, expected, actual);
		end
	endtask

	task automatic check_addr(input string what, input reg_addr_t expected,
			input reg_addr_t actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s: expected %0d, actual %0d", what, expected, actual);
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s: expected %b, actual %b", what, expected, actual);
		end
	endtask

	// drive one slot on the falling edge and queue what it should produce
	task automatic issue_instr(input string name, input logic valid, input opcode_t op,
			input reg_addr_t d, input reg_addr_t sa, input reg_addr_t sb, input imm_t im,
			input logic uc, input logic ui);
		expect_t e;
		@(negedge clock);
		instr_valid = valid;
		opcode      = op;
		dest        = d;
		src_a       = sa;
		src_b       = sb;
		imm         = im;
		use_carry   = uc;
		use_imm     = ui;
		e = model_step(valid, op, d, sa, sb, im, uc, ui);
		exp_q.push_back(e);
		name_q.push_back(name);
	endtask

	task automatic issue_random(input string name, input opcode_t op, input logic valid,
			input logic carry_ok, input logic ui);
		logic [31:0] r;
		reg_addr_t   sa;
		reg_addr_t   sb;
		r  = next_rand();
		sa = r[11:6];
		sb = r[17:12];
		if (r[19:18] == 2'b00) begin
			sa = last_dest;  // reads the previous result
		end
		if (r[21:20] == 2'b00) begin
			sb = sa;         // equal operands for the compares
		end
		last_dest = r[5:0];
		issue_instr(name, valid, op, r[5:0], sa, sb, imm_t'(next_rand()), carry_ok & r[22], ui);
	endtask

	// outputs seen at this edge belong to the slot queued one cycle earlier
	always @(posedge clock) begin
		if (have_cur) begin
			check_bit({cur_name, " wb_valid"}, cur.wb_valid, wb_valid);
			check_bit({cur_name, " branch_taken"}, cur.branch_taken, branch_taken);
			check_bit({cur_name, " carry"}, cur.carry, carry);
			check_bit({cur_name, " halted"}, cur.halted, halted);
			if (cur.wb_valid) begin
				check_addr({cur_name, " wb_addr"}, cur.wb_addr, wb_addr);
				check_word({cur_name, " wb_data"}, cur.wb_data, wb_data);
			end
			if (cur.branch_taken) begin
				check_word({cur_name, " pc_offset"}, cur.pc_offset, pc_offset);
			end
		end
		have_cur = (exp_q.size() > 0);
		if (have_cur) begin
			cur      = exp_q.pop_front();
			cur_name = name_q.pop_front();
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d mismatches, %0d other, %0d checks", mismatch_count,
				other_errors, check_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		opcode      = OP_NOP;
		dest        = '0;
		src_a       = '0;
		src_b       = '0;
		imm         = '0;
		use_carry   = 1'b0;
		use_imm     = 1'b0;
		rng_state   = 32'h202d8699;
		clear_shadow();
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		issue_instr("after reset", 1'b0, OP_NOP, '0, '0, '0, '0, 1'b0, 1'b0);
		for (int i = 0; i < NUM_REGS; i++) begin
			issue_instr("mov after reset", 1'b1, OP_MOV, reg_addr_t'(i), reg_addr_t'(i), '0,
				imm_t'(next_rand()), 1'b0, 1'b0);
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			issue_instr("movi seed", 1'b1, OP_MOVI, reg_addr_t'(i), '0, '0, imm_t'(next_rand()),
				1'b0, 1'b0);
		end
		for (int i = 0; i < N_REG; i++) begin
			issue_random("register op", reg_ops[4'(next_rand() % 32'd9)], 1'b1, 1'b0, 1'b0);
		end
		for (int i = 0; i < N_IMM; i++) begin
			r = next_rand();
			issue_random("immediate op", imm_ops[4'(r % 32'd9)], |r[29:28], 1'b0, 1'b1);
		end
		for (int i = 0; i < N_CARRY; i++) begin
			r = next_rand();
			issue_random("carry chain", carry_ops[r[2:0]], 1'b1, 1'b1, r[3]);
		end
		for (int i = 0; i < N_BRANCH; i++) begin
			issue_random("branch", br_ops[3'(next_rand() % 32'd7)], 1'b1, 1'b0, 1'b0);
		end
		for (int i = 0; i < N_NOP; i++) begin
			r = next_rand();
			// codes 16 to 31 are unused
			issue_instr("nop or unused code", 1'b1, r[0] ? OP_NOP : opcode_t'({2'b01, r[4:1]}),
				r[10:5], r[16:11], r[22:17], imm_t'(r[31:16] | 16'h0001), r[23], r[24]);
		end
		issue_instr("breakpoint", 1'b1, OP_NOP, '0, '0, '0, '0, 1'b0, 1'b0);
		for (int i = 0; i < N_POST; i++) begin
			r = next_rand();
			issue_random("after halt", opcode_t'(r[5:0]), r[6], 1'b1, r[7]);
		end
		issue_instr("idle", 1'b0, OP_NOP, '0, '0, '0, '0, 1'b0, 1'b0);
		issue_instr("idle", 1'b0, OP_NOP, '0, '0, '0, '0, 1'b0, 1'b0);
		@(posedge clock);
		@(posedge clock);
		@(negedge clock);

		if (exp_q.size() != 0) begin
			other_errors++;
			$display("expected results left unchecked at end of run: %0d", exp_q.size());
		end
		$display("errors: %0d mismatches, %0d other, %0d checks", mismatch_count,
			other_errors, check_count);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  exec_pkg::opcode_t   opcode,
	input  exec_pkg::reg_addr_t dest,
	input  exec_pkg::reg_addr_t src_a,
	input  exec_pkg::reg_addr_t src_b,
	input  exec_pkg::imm_t      imm,
	input  logic               use_carry,
	input  logic               use_imm,
	output logic               wb_valid,
	output exec_pkg::reg_addr_t wb_addr,
	output exec_pkg::word_t     wb_data,
	output logic               carry,
	output logic               branch_taken,
	output exec_pkg::word_t     pc_offset,
	output logic               halted
);
	import exec_pkg::*;

	word_t     rd_data_a;
	word_t     rd_data_b;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	operand_if ops ();

	reg_file u_reg_file (
		.clock     (clock),
		.rst_n     (rst_n),
		.rd_addr_a (src_a),
		.rd_addr_b (src_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	op_decode u_op_decode (
		.opcode      (opcode),
		.dest        (dest),
		.imm         (imm),
		.use_carry   (use_carry),
		.use_imm     (use_imm),
		.instr_valid (instr_valid),
		.halted      (halted),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.ops         (ops.dec)
	);

	alu_core u_alu_core (
		.clock    (clock),
		.rst_n    (rst_n),
		.ops      (ops.alu),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wb_valid (wb_valid),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.carry    (carry)
	);

	branch_unit u_branch_unit (
		.clock        (clock),
		.rst_n        (rst_n),
		.ops          (ops.br),
		.branch_taken (branch_taken),
		.pc_offset    (pc_offset),
		.halted       (halted)
	);

endmodule

`default_nettype wire

//--- verilog/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode (
	input  exec_pkg::opcode_t   opcode,
	input  exec_pkg::reg_addr_t dest,
	input  exec_pkg::imm_t      imm,
	input  logic               use_carry,
	input  logic               use_imm,
	input  logic               instr_valid,
	input  logic               halted,
	input  exec_pkg::word_t     rd_data_a,
	input  exec_pkg::word_t     rd_data_b,
	operand_if.dec             ops
);
	import exec_pkg::*;

	word_t imm_small;
	word_t imm_logic;
	word_t imm_cond;
	logic  exec_en;

	assign imm_small = {{(WORD_W-IMM_SMALL_W){1'b0}}, imm[IMM_SMALL_W-1:0]};
	assign imm_logic = {{(WORD_W-IMM_LOGIC_W){1'b0}}, imm[IMM_LOGIC_W-1:0]};
	assign imm_cond  = {{(WORD_W-IMM_COND_W){imm[IMM_COND_W-1]}}, imm[IMM_COND_W-1:0]};

	assign exec_en = instr_valid & ~halted;  // nothing issues once halted

	assign ops.exec_en  = exec_en;
	assign ops.a        = rd_data_a;
	assign ops.dest     = dest;
	assign ops.halt_req = exec_en && (opcode == OP_NOP) && (imm == '0);

	always_comb begin
		ops.alu_op    = ALU_NONE;
		ops.br_cond   = BR_NONE;
		ops.b         = rd_data_b;
		ops.offset    = imm_cond;
		ops.use_carry = 1'b0;
		case (opcode)
			OP_ADD: begin
				ops.alu_op    = ALU_ADD;
				ops.use_carry = use_carry;
			end
			OP_SUB: begin
				ops.alu_op    = ALU_SUB;
				ops.use_carry = use_carry;  // borrow mode
			end
			OP_AND: begin
				ops.alu_op = ALU_AND;
				ops.b      = use_imm ? imm_logic : rd_data_b;
			end
			OP_OR: begin
				ops.alu_op = ALU_OR;
				ops.b      = use_imm ? imm_logic : rd_data_b;
			end
			OP_XOR: begin
				ops.alu_op = ALU_XOR;
				ops.b      = use_imm ? imm_logic : rd_data_b;
			end
			OP_ASR:  ops.alu_op = ALU_ASR;
			OP_LSL:  ops.alu_op = ALU_LSL;
			OP_LSR:  ops.alu_op = ALU_LSR;
			OP_MOV:  ops.alu_op = ALU_PASS_A;
			OP_ADDI: begin
				ops.alu_op = ALU_ADD;
				ops.b      = imm_small;
			end
			OP_SUBI: begin
				ops.alu_op = ALU_SUB;
				ops.b      = imm_small;
			end
			OP_ASRI: begin
				ops.alu_op = ALU_ASR;
				ops.b      = imm_small;
			end
			OP_LSLI: begin
				ops.alu_op = ALU_LSL;
				ops.b      = imm_small;
			end
			OP_LSRI: begin
				ops.alu_op = ALU_LSR;
				ops.b      = imm_small;
			end
			OP_MOVI: begin
				ops.alu_op = ALU_PASS_B;
				ops.b      = imm;      // all 16 bits
			end
			OP_BR: begin
				ops.br_cond = BR_ALWAYS;
				ops.offset  = imm;     // full width signed offset
			end
			OP_BEQ:  ops.br_cond = BR_EQ;
			OP_BNE:  ops.br_cond = BR_NE;
			OP_BLT:  ops.br_cond = BR_LT;
			OP_BGT:  ops.br_cond = BR_GT;
			OP_BLTU: ops.br_cond = BR_LTU;
			OP_BGTU: ops.br_cond = BR_GTU;
			default: ;                 // nop and unknown codes
		endcase
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
common/exec_pkg.sv
common/operand_if.sv
regfile/reg_file.sv
alu/alu_core.sv
branch/branch_unit.sv
verilog/op_decode.sv
verilog/exec_top.sv
verification/exec_tb.sv
